/* common/matvec_pkg.sv */
package matvec_pkg;

    // Array geometry
    localparam int NUM_CORES = 8;
    localparam int MAT_DEPTH = 128;
    localparam int WORD_W    = 32;

    // Cycles between the last accumulate issue and the first output cycle
    localparam int DRAIN_CYC = 2;

    typedef logic [WORD_W-1:0]              word_t;
    typedef logic [$clog2(MAT_DEPTH)-1:0]   col_addr_t;
    typedef logic [$clog2(NUM_CORES)-1:0]   core_sel_t;
    typedef logic [$clog2(MAT_DEPTH):0]     run_len_t;   // Holds 1 to 128

    // Matrix write beat
    // data[0] goes to addr and data[1] to addr + 1
    typedef struct packed {
        core_sel_t   core_sel;
        col_addr_t   addr;
        word_t [1:0] data;
    } mat_beat_t;

    // Source vector write
    typedef struct packed {
        col_addr_t addr;
        word_t     data;
    } vec_wr_t;

    // Broadcast from the sequencer to every core
    typedef struct packed {
        logic init;
        logic exec;
        logic out_period;
        logic update;
    } core_ctrl_t;

endpackage

/* mac_core/mac_core.sv */
`timescale 1ns/10ps

module mac_core (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    core_wr_v,
    input  matvec_pkg::col_addr_t   core_wr_addr,
    input  matvec_pkg::word_t [1:0] core_wr_data,
    input  matvec_pkg::core_ctrl_t  ctrl,
    input  matvec_pkg::col_addr_t   col_addr,
    input  matvec_pkg::word_t       src_data,
    input  matvec_pkg::word_t       acc_next,
    output matvec_pkg::word_t       acc
);
    import matvec_pkg::*;

    word_t     row_mem [MAT_DEPTH];
    col_addr_t wr_addr_hi;
    word_t     mat_data;          // Row word read by exec
    word_t     mat_op;
    word_t     src_op;
    word_t     acc_sum;
    word_t     acc_shift;
    logic      init_d1, init_d2;
    logic      exec_d1, exec_d2;

    // Loader only passes even addresses, so this never wraps
    assign wr_addr_hi = core_wr_addr + 1'b1;

    // Own result during update, chain value afterwards
    assign acc = ctrl.update ? acc_sum : acc_shift;

    always_ff @(posedge clk) begin
        if (core_wr_v) begin
            row_mem[core_wr_addr] <= core_wr_data[0];
            row_mem[wr_addr_hi]   <= core_wr_data[1];
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.exec) begin
            mat_data <= row_mem[col_addr];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            init_d1 <= 1'b0;
            init_d2 <= 1'b0;
            exec_d1 <= 1'b0;
            exec_d2 <= 1'b0;
        end else begin
            init_d1 <= ctrl.init;
            init_d2 <= init_d1;
            exec_d1 <= ctrl.exec;
            exec_d2 <= exec_d1;
        end
    end

    // Operand register ahead of the multiplier for timing
    always_ff @(posedge clk) begin
        if (exec_d1) begin
            mat_op <= mat_data;
            src_op <= src_data;   // Vector word arrives one cycle after exec
        end
    end

    always_ff @(posedge clk) begin
        if (init_d2) begin
            acc_sum <= '0;
        end else if (exec_d2) begin
            acc_sum <= acc_sum + mat_op * src_op;
        end
        if (ctrl.out_period) begin
            acc_shift <= acc_next;
        end
    end

endmodule

/* hdl/matrix_loader.sv */
`timescale 1ns/10ps

module matrix_loader (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                mat_v,
    input  matvec_pkg::mat_beat_t               mat_beat,
    output logic [matvec_pkg::NUM_CORES-1:0]    core_wr_v,
    output matvec_pkg::col_addr_t               core_wr_addr,
    output matvec_pkg::word_t [1:0]             core_wr_data,
    output logic                                load_error
);
    import matvec_pkg::*;

    logic misaligned;

    // A pair must start on an even word
    assign misaligned = mat_beat.addr[0];

    // One-hot strobe toward the selected row only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_wr_v  <= '0;
            load_error <= 1'b0;
        end else begin
            core_wr_v <= '0;
            if (mat_v && !misaligned) begin
                core_wr_v[mat_beat.core_sel] <= 1'b1;
            end
            load_error <= mat_v && misaligned;
        end
    end

    // Shared by all cores
    always_ff @(posedge clk) begin
        if (mat_v) begin
            core_wr_addr <= mat_beat.addr;
            core_wr_data <= mat_beat.data;
        end
    end

endmodule

/* hdl/vector_store.sv */
`timescale 1ns/10ps

module vector_store (
    input  logic                  clk,
    input  logic                  wr_en,
    input  matvec_pkg::vec_wr_t   wr,
    input  logic                  rd_en,
    input  matvec_pkg::col_addr_t rd_addr,
    output matvec_pkg::word_t     rd_data
);
    import matvec_pkg::*;

    word_t vec_mem [MAT_DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            vec_mem[wr.addr] <= wr.data;
        end
    end

    // Registered read lines up with the core row read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= vec_mem[rd_addr];
        end
    end

endmodule

/* hdl/exec_sequencer.sv */
`timescale 1ns/10ps

module exec_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  matvec_pkg::run_len_t   length,
    output matvec_pkg::core_ctrl_t ctrl,
    output matvec_pkg::col_addr_t  col_addr,
    output logic                   busy,
    output logic                   result_valid
);
    import matvec_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_INIT,
        ST_EXEC,
        ST_DRAIN,
        ST_OUT
    } state_t;

    state_t    state;
    run_len_t  len_q;
    col_addr_t col_cnt;
    logic [1:0] drain_cnt;
    core_sel_t out_cnt;
    logic      last_col;

    assign last_col = ({1'b0, col_cnt} == len_q - 1'b1);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            len_q     <= '0;
            col_cnt   <= '0;
            drain_cnt <= '0;
            out_cnt   <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Zero length would never finish
                    if (start && length != '0) begin
                        len_q <= length;
                        state <= ST_INIT;
                    end
                end
                ST_INIT: begin
                    col_cnt <= '0;
                    state   <= ST_EXEC;
                end
                ST_EXEC: begin
                    if (last_col) begin
                        drain_cnt <= '0;
                        state     <= ST_DRAIN;
                    end else begin
                        col_cnt <= col_cnt + 1'b1;
                    end
                end
                ST_DRAIN: begin   // Let the MAC pipeline empty
                    if (drain_cnt == 2'(DRAIN_CYC - 1)) begin
                        out_cnt <= '0;
                        state   <= ST_OUT;
                    end else begin
                        drain_cnt <= drain_cnt + 1'b1;
                    end
                end
                ST_OUT: begin
                    if (out_cnt == core_sel_t'(NUM_CORES - 1)) begin
                        state <= ST_IDLE;
                    end else begin
                        out_cnt <= out_cnt + 1'b1;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    always_comb begin
        ctrl.init       = (state == ST_INIT);
        ctrl.exec       = (state == ST_EXEC);
        ctrl.out_period = (state == ST_OUT);
        ctrl.update     = (state == ST_OUT) && (out_cnt == '0);  // First output cycle only
    end

    assign col_addr     = col_cnt;
    assign busy         = (state != ST_IDLE);
    assign result_valid = (state == ST_OUT);

endmodule

/* hdl/matvec_top.sv */
`timescale 1ns/10ps

module matvec_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  mat_v,
    input  matvec_pkg::mat_beat_t mat_beat,
    input  logic                  vec_wr_en,
    input  matvec_pkg::vec_wr_t   vec_wr,
    input  logic                  start,
    input  matvec_pkg::run_len_t  length,
    output logic                  busy,
    output logic                  result_valid,
    output matvec_pkg::word_t     result,
    output logic                  load_error
);
    import matvec_pkg::*;

    logic [NUM_CORES-1:0] core_wr_v;
    col_addr_t            core_wr_addr;
    word_t [1:0]          core_wr_data;
    core_ctrl_t           ctrl;
    col_addr_t            col_addr;
    word_t                src_data;
    word_t [NUM_CORES:0]  acc_chain;   // Entry i is the acc of core i

    assign acc_chain[NUM_CORES] = '0;     // End of the shift chain
    assign result               = acc_chain[0];

    matrix_loader i_matrix_loader (
        .clk,
        .rst_n,
        .mat_v,
        .mat_beat,
        .core_wr_v,
        .core_wr_addr,
        .core_wr_data,
        .load_error
    );

    vector_store i_vector_store (
        .clk,
        .wr_en   (vec_wr_en),
        .wr      (vec_wr),
        .rd_en   (ctrl.exec),
        .rd_addr (col_addr),
        .rd_data (src_data)
    );

    exec_sequencer i_exec_sequencer (
        .clk,
        .rst_n,
        .start,
        .length,
        .ctrl,
        .col_addr,
        .busy,
        .result_valid
    );

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        mac_core i_mac_core (
            .clk,
            .rst_n,
            .core_wr_v    (core_wr_v[i]),
            .core_wr_addr,
            .core_wr_data,
            .ctrl,
            .col_addr,
            .src_data,
            .acc_next     (acc_chain[i+1]),
            .acc          (acc_chain[i])
        );
    end

endmodule

/* sim/matvec_properties.sv */
`timescale 1ns/10ps

module matvec_properties (
    input logic                   clk,
    input logic                   rst_n,
    input matvec_pkg::core_ctrl_t ctrl,
    input logic                   result_valid
);
    int unsigned prop_fail_cnt = 0;

    update_single: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.update |=> !ctrl.update)
        else begin
            $error("update held for more than one cycle");
            prop_fail_cnt++;
        end

    // Update marks the first output cycle
    update_first_out: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.update == $rose(ctrl.out_period))
        else begin
            $error("update not aligned with the first out_period cycle");
            prop_fail_cnt++;
        end

    out_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ctrl.out_period) |-> ctrl.out_period [*8] ##1 !ctrl.out_period)
        else begin
            $error("out_period did not last eight cycles");
            prop_fail_cnt++;
        end

    init_vs_exec: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.init && ctrl.exec))
        else begin
            $error("init and exec high together");
            prop_fail_cnt++;
        end

    exec_vs_out: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.exec && result_valid))
        else begin
            $error("exec high while results stream");
            prop_fail_cnt++;
        end

endmodule

bind exec_sequencer matvec_properties i_matvec_properties (
    .clk,
    .rst_n,
    .ctrl,
    .result_valid
);

/* sim/tb_matvec.sv */
`timescale 1ns/10ps

module tb_matvec;
    import matvec_pkg::*;

    localparam int WAIT_LIMIT = 400;

    logic      clk, rst_n, mat_v, vec_wr_en, start;
    mat_beat_t mat_beat;
    vec_wr_t   vec_wr;
    run_len_t  length;
    logic      busy, result_valid, load_error;
    word_t     result;

    word_t    mat_model [NUM_CORES][MAT_DEPTH];
    word_t    vec_model [MAT_DEPTH];
    int       seed = 48;
    int       mismatch_cnt = 0;
    int       fail_cnt = 0;
    bit       started = 0;
    run_len_t n_rand;

    matvec_top i_matvec_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Sequencer must stay quiet until the first start
    always @(negedge clk) begin
        if (rst_n && !started) begin
            assert (!busy && !result_valid) else begin
                fail_cnt++;
                $display("busy or result_valid went high before any start at %0t", $time);
            end
        end
    end

    function automatic word_t dot(input int core, input int n);
        word_t sum;
        sum = '0;
        for (int c = 0; c < n; c++) sum = sum + mat_model[core][c] * vec_model[c];
        return sum;
    endfunction

    task automatic report_mismatch(input string name, input word_t exp, input word_t act);
        mismatch_cnt++;
        $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
    endtask

    task automatic end_sim();
        int prop_cnt;
        prop_cnt = i_matvec_top.i_exec_sequencer.i_matvec_properties.prop_fail_cnt;
        $display("Done with %0d mismatches, %0d other failures, %0d assertion failures",
                 mismatch_cnt, fail_cnt, prop_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0 && prop_cnt == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        fail_cnt++;
        $display("timeout at %0t while waiting for %s", $time, what);
        end_sim();
    endtask

    task automatic send_beat(input int core, input int addr, input word_t hi, input word_t lo);
        @(posedge clk);
        mat_v             <= 1'b1;
        mat_beat.core_sel <= core_sel_t'(core);
        mat_beat.addr     <= col_addr_t'(addr);
        mat_beat.data     <= {hi, lo};
        @(posedge clk);
        mat_v             <= 1'b0;
    endtask

    task automatic write_row(input int core);
        word_t lo, hi;
        for (int a = 0; a < MAT_DEPTH; a += 2) begin
            lo = $random(seed);
            hi = $random(seed);
            send_beat(core, a, hi, lo);
            mat_model[core][a]   = lo;
            mat_model[core][a+1] = hi;
        end
    endtask

    task automatic write_vector();
        word_t v;
        for (int a = 0; a < MAT_DEPTH; a++) begin
            @(posedge clk);
            v = $random(seed);
            vec_wr_en    <= 1'b1;
            vec_wr.addr  <= col_addr_t'(a);
            vec_wr.data  <= v;
            vec_model[a] = v;
        end
        @(posedge clk);
        vec_wr_en <= 1'b0;
    endtask

    task automatic bad_beat(input int core, input int addr);
        send_beat(core, addr, $random(seed), $random(seed));   // Model left untouched
        @(negedge clk);
        assert (load_error === 1'b1) else report_mismatch("load_error", 1, load_error);
        @(negedge clk);
        assert (load_error === 1'b0) else report_mismatch("load_error", 0, load_error);
    endtask

    // Second start pulse at cycle intrude_at of the run, 0 for none
    task automatic run_and_check(input run_len_t n, input int intrude_at);
        word_t exp [NUM_CORES];
        int    j;
        for (int k = 0; k < NUM_CORES; k++) exp[k] = dot(k, n);
        started = 1'b1;
        @(posedge clk);
        start  <= 1'b1;
        length <= n;
        j = 0;
        do begin
            @(posedge clk);
            j++;
            start <= (j == intrude_at);
            if (j == intrude_at) length <= run_len_t'(3);
            @(negedge clk);
            if (j > WAIT_LIMIT) report_timeout("the first result");
        end while (!result_valid);
        assert (j == n + 4) else report_mismatch("result latency", n + 4, j);
        for (int k = 0; k < NUM_CORES; k++) begin
            if (k > 0) @(negedge clk);
            assert (result_valid === 1'b1) else report_mismatch("result_valid", 1, result_valid);
            assert (result === exp[k])
                else report_mismatch($sformatf("result[%0d]", k), exp[k], result);
        end
        @(negedge clk);
        assert (result_valid === 1'b0) else report_mismatch("result_valid", 0, result_valid);
        j = 0;
        while (busy) begin
            @(negedge clk);
            j++;
            if (j > WAIT_LIMIT) report_timeout("busy to fall after the results");
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        mat_v     = 1'b0;
        mat_beat  = '0;
        vec_wr_en = 1'b0;
        vec_wr    = '0;
        start     = 1'b0;
        length    = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        for (int c = 0; c < NUM_CORES; c++) write_row(c);
        write_vector();
        run_and_check(128, 0);
        run_and_check(5, 0);
        run_and_check(128, 0);           // Back to back, no reload
        run_and_check(128, 0);
        run_and_check(20, 5);            // Start during a run is dropped
        repeat (4) begin
            @(negedge clk);
            assert (!busy) else begin
                fail_cnt++;
                $display("busy rose again after an ignored start at %0t", $time);
            end
        end
        bad_beat(3, 37);
        run_and_check(128, 0);
        n_rand = run_len_t'(($random(seed) & 127) + 1);
        run_and_check(n_rand, 0);
        end_sim();
    end

endmodule

/* tb.f */
common/matvec_pkg.sv
mac_core/mac_core.sv
hdl/matrix_loader.sv
hdl/vector_store.sv
hdl/exec_sequencer.sv
hdl/matvec_top.sv
sim/matvec_properties.sv
sim/tb_matvec.sv

/* Bender.yml */
package:
  name: matvec

sources:
  - common/matvec_pkg.sv
  - mac_core/mac_core.sv
  - hdl/matrix_loader.sv
  - hdl/vector_store.sv
  - hdl/exec_sequencer.sv
  - hdl/matvec_top.sv
  - target: test
    files:
      - sim/matvec_properties.sv
      - sim/tb_matvec.sv
